//--- design/control_unit.sv
// cycle sequencer and opcode decoder of the CPU; drives the datapath controls per cycle
`timescale 1ns/100ps

module control_unit import ls_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  opcode_t opcode,
    input  logic    fetch_done,
    input  logic    mem_done,
    output cycle_t  cycle,
    output ctrl_t   ctrl
);

    logic   is_alu;
    logic   is_load;
    logic   is_store;
    logic   is_branch;
    cycle_t next_cycle;

    // opcode classes
    assign is_alu    = (opcode == op_add) || (opcode == op_sub) || (opcode == op_and) ||
                       (opcode == op_or)  || (opcode == op_addi);
    assign is_load   = (opcode == op_lw);
    assign is_store  = (opcode == op_sw);
    assign is_branch = (opcode == op_beq) || (opcode == op_bgt);

    always_comb begin
        next_cycle = cycle;
        case (cycle)
            st_fetch: begin
                if (fetch_done) begin
                    next_cycle = st_decode;
                end
            end
            st_decode: begin
                next_cycle = (opcode == op_halt) ? st_halt : st_execute;
            end
            st_execute: begin
                if (is_load || is_store) begin
                    next_cycle = st_mem;
                end else if (is_alu) begin
                    next_cycle = st_writeback;
                end else begin
                    // branches and unused codes end here
                    next_cycle = st_fetch;
                end
            end
            st_mem: begin
                if (mem_done) begin
                    next_cycle = is_load ? st_writeback : st_fetch;
                end
            end
            st_writeback: next_cycle = st_fetch;
            default:      next_cycle = st_halt;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= st_fetch;
        end else begin
            cycle <= next_cycle;
        end
    end

    // each control is live only in the cycle where it acts
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (cycle)
            st_fetch: begin
                ctrl.pc_write = fetch_done;
            end
            st_execute: begin
                case (opcode)
                    op_sub, op_beq, op_bgt: ctrl.alu_op = alu_sub;
                    op_and:                 ctrl.alu_op = alu_and;
                    op_or:                  ctrl.alu_op = alu_or;
                    default:                ctrl.alu_op = alu_add;
                endcase
                ctrl.alu_src_imm   = (opcode == op_addi) || is_load || is_store;
                ctrl.branch        = is_branch;
                ctrl.branch_on_pos = (opcode == op_bgt);
                // fetch stage only takes the target when the branch resolves taken
                ctrl.pc_write      = is_branch;
            end
            st_mem: begin
                ctrl.mem_read  = is_load;
                ctrl.mem_write = is_store;
            end
            st_writeback: begin
                ctrl.reg_write = is_alu || is_load;
            end
            default: ;
        endcase
    end

endmodule

//--- design/decode_stage.sv
// register file, field extraction and immediate generation; fills the decode-execute register
`timescale 1ns/100ps

module decode_stage import ls_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  cycle_t           cycle,
    input  logic [XLEN-1:0]  ir,
    input  logic [XLEN-1:0]  pc,
    input  logic             wb_en,
    input  logic [REG_W-1:0] wb_rd,
    input  logic [XLEN-1:0]  wb_data,
    output de_reg_t          de,
    output opcode_t          opcode
);

    logic [XLEN-1:0]  regs [NREG];
    logic [REG_W-1:0] rd_f;
    logic [REG_W-1:0] rs1_f;
    logic [REG_W-1:0] rs2_f;
    logic [REG_W-1:0] src2;
    logic [IMM_W-1:0] imm_f;
    logic [XLEN-1:0]  imm_ext;
    logic [XLEN-1:0]  rdata1;
    logic [XLEN-1:0]  rdata2;

    assign opcode = opcode_t'(ir[OP_LSB +: 4]);
    assign rd_f   = ir[RD_LSB +: REG_W];
    assign rs1_f  = ir[RS1_LSB +: REG_W];
    assign rs2_f  = ir[RS2_LSB +: REG_W];
    assign imm_f  = ir[IMM_W-1:0];

    assign imm_ext = {{(XLEN-IMM_W){imm_f[IMM_W-1]}}, imm_f};

    // store data and branch compare operand come from the rd field
    assign src2 = ((opcode == op_sw) || (opcode == op_beq) || (opcode == op_bgt)) ?
                  rd_f : rs2_f;

    // r0 reads as zero regardless of contents
    assign rdata1 = (rs1_f == '0) ? '0 : regs[rs1_f];
    assign rdata2 = (src2 == '0) ? '0 : regs[src2];

    always_ff @(posedge clock) begin
        if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // de register, loaded once per instruction
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            de <= '0;
        end else if (cycle == st_decode) begin
            de.pc  <= pc;
            de.a   <= rdata1;
            de.b   <= rdata2;
            de.rd  <= rd_f;
            de.imm <= imm_ext;
        end
    end

endmodule

//--- design/execute_stage.sv
// ALU, flags and branch resolution; fills the execute-memory register
`timescale 1ns/100ps

module execute_stage import ls_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  cycle_t          cycle,
    input  ctrl_t           ctrl,
    input  de_reg_t         de,
    output em_reg_t         em,
    output logic            take_branch,
    output logic [XLEN-1:0] target
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            zero;
    logic            pos;

    assign op_b = ctrl.alu_src_imm ? de.imm : de.b;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: result = de.a - op_b;
            alu_and: result = de.a & op_b;
            alu_or:  result = de.a | op_b;
            default: result = de.a + op_b;
        endcase
    end

    assign zero = (result == '0);
    // positive and nonzero when read as signed
    assign pos  = !result[XLEN-1] && !zero;

    // de.pc already points past the branch
    assign target      = de.pc + de.imm;
    assign take_branch = ctrl.branch && (ctrl.branch_on_pos ? pos : zero);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            em <= '0;
        end else if (cycle == st_execute) begin
            em.aluout <= result;
            em.b      <= de.b;
            em.rd     <= de.rd;
            em.zero   <= zero;
            em.pos    <= pos;
            em.target <= target;
        end
    end

endmodule

//--- design/fetch_stage.sv
// program counter and instruction fetch; holds the fetch-decode instruction register
`timescale 1ns/100ps

module fetch_stage import ls_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  cycle_t          cycle,
    input  logic            pc_write,
    input  logic            take_branch,
    input  logic [XLEN-1:0] target,
    input  logic            bus_ready,
    input  logic [XLEN-1:0] bus_rdata,
    output logic            fetch_valid,
    output bus_req_t        fetch_req,
    output logic            fetch_done,
    output logic [XLEN-1:0] ir,
    output logic [XLEN-1:0] pc
);

    assign fetch_valid     = (cycle == st_fetch);
    assign fetch_done      = fetch_valid && bus_ready;
    assign fetch_req.kind  = bus_fetch;
    assign fetch_req.addr  = pc;
    assign fetch_req.wdata = '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_write) begin
            if (take_branch) begin
                pc <= target;
            end else if (cycle == st_fetch) begin
                pc <= pc + XLEN'(1);
            end
        end
    end

    // fd instruction register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (fetch_done) begin
            ir <= bus_rdata;
        end
    end

endmodule

//--- design/ls_cpu.sv
// top level of the multi-cycle load-store CPU; joins control and stages onto one memory bus
`timescale 1ns/100ps

module ls_cpu import ls_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    output logic            bus_valid,
    output bus_req_t        bus_req,
    input  logic            bus_ready,
    input  logic [XLEN-1:0] bus_rdata,
    output logic            halted
);

    cycle_t           cycle;
    ctrl_t            ctrl;
    opcode_t          opcode;
    logic             fetch_valid;
    logic             fetch_done;
    bus_req_t         fetch_req;
    logic             mem_valid;
    logic             mem_done;
    bus_req_t         mem_req;
    logic [XLEN-1:0]  ir;
    logic [XLEN-1:0]  pc;
    logic             take_branch;
    logic [XLEN-1:0]  target;
    de_reg_t          de;
    em_reg_t          em;
    logic             wb_en;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0]  wb_data;

    control_unit u_control (
        .clock      (clock),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .fetch_done (fetch_done),
        .mem_done   (mem_done),
        .cycle      (cycle),
        .ctrl       (ctrl)
    );

    fetch_stage u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .cycle       (cycle),
        .pc_write    (ctrl.pc_write),
        .take_branch (take_branch),
        .target      (target),
        .bus_ready   (bus_ready),
        .bus_rdata   (bus_rdata),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .fetch_done  (fetch_done),
        .ir          (ir),
        .pc          (pc)
    );

    decode_stage u_decode (
        .clock   (clock),
        .rst_n   (rst_n),
        .cycle   (cycle),
        .ir      (ir),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .de      (de),
        .opcode  (opcode)
    );

    execute_stage u_execute (
        .clock       (clock),
        .rst_n       (rst_n),
        .cycle       (cycle),
        .ctrl        (ctrl),
        .de          (de),
        .em          (em),
        .take_branch (take_branch),
        .target      (target)
    );

    mem_stage u_mem (
        .clock     (clock),
        .rst_n     (rst_n),
        .cycle     (cycle),
        .ctrl      (ctrl),
        .em        (em),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // bus owner follows the cycle, idle otherwise
    always_comb begin
        bus_valid = 1'b0;
        bus_req   = fetch_req;
        case (cycle)
            st_fetch: begin
                bus_valid = fetch_valid;
                bus_req   = fetch_req;
            end
            st_mem: begin
                bus_valid = mem_valid;
                bus_req   = mem_req;
            end
            default: ;
        endcase
    end

    assign halted = (cycle == st_halt);

endmodule

//--- design/ls_pkg.sv
// shared ISA constants, enums and structs for the load-store CPU; import into each module
package ls_pkg;

    localparam int XLEN  = 16;
    localparam int NREG  = 8;
    localparam int IMM_W = 6;
    localparam int REG_W = $clog2(NREG);

    // instruction field positions
    localparam int OP_LSB  = 12;
    localparam int RD_LSB  = 9;
    localparam int RS1_LSB = 6;
    localparam int RS2_LSB = 3;

    // sw, beq and bgt carry an immediate in bits 5..0, so their
    // second source register sits in the rd field instead
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_addi = 4'h4,
        op_lw   = 4'h5,
        op_sw   = 4'h6,
        op_beq  = 4'h7,
        op_bgt  = 4'h8,
        op_halt = 4'h9
    } opcode_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_mem,
        st_writeback,
        st_halt
    } cycle_t;

    typedef enum logic [1:0] {
        bus_fetch,
        bus_read,
        bus_write
    } bus_kind_t;

    typedef struct packed {
        bus_kind_t       kind;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    pc_write;
        logic    branch;
        logic    branch_on_pos;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  imm;
    } de_reg_t;

    typedef struct packed {
        logic [XLEN-1:0]  aluout;
        logic [XLEN-1:0]  b;
        logic [REG_W-1:0] rd;
        logic             zero;
        logic             pos;
        logic [XLEN-1:0]  target;
    } em_reg_t;

endpackage

//--- design/mem_stage.sv
// load/store bus requests, memory-writeback register and writeback select
`timescale 1ns/100ps

module mem_stage import ls_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  cycle_t           cycle,
    input  ctrl_t            ctrl,
    input  em_reg_t          em,
    input  logic             bus_ready,
    input  logic [XLEN-1:0]  bus_rdata,
    output logic             mem_valid,
    output bus_req_t         mem_req,
    output logic             mem_done,
    output logic             wb_en,
    output logic [REG_W-1:0] wb_rd,
    output logic [XLEN-1:0]  wb_data
);

    logic [XLEN-1:0] mw_data;
    logic            mw_load;

    assign mem_valid     = (cycle == st_mem) && (ctrl.mem_read || ctrl.mem_write);
    assign mem_done      = mem_valid && bus_ready;
    assign mem_req.kind  = ctrl.mem_write ? bus_write : bus_read;
    assign mem_req.addr  = em.aluout;
    assign mem_req.wdata = em.b;

    // mw register; load flag cleared each execute so ALU ops write back aluout
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_data <= '0;
            mw_load <= 1'b0;
        end else if (cycle == st_execute) begin
            mw_load <= 1'b0;
        end else if (mem_done) begin
            mw_data <= bus_rdata;
            mw_load <= ctrl.mem_read;
        end
    end

    assign wb_en   = (cycle == st_writeback) && ctrl.reg_write;
    assign wb_rd   = em.rd;
    assign wb_data = mw_load ? mw_data : em.aluout;

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ls_cpu -f tb.f -o tb_ls_cpu || exit 1
result="$(./obj_dir/tb_ls_cpu)"
echo "$result"
echo "$result" | grep -qx "PASS: all tests" && exit 0 || exit 1

//--- sim/ls_checker.sv
// bus monitor with a reference instruction model; compares every bus transfer of the CPU
`timescale 1ns/100ps

module ls_checker import ls_pkg::*; (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            bus_valid,
    input  bus_req_t        bus_req,
    input  logic            bus_ready,
    input  logic            halted,
    input  logic [XLEN-1:0] init_image [256],
    output int              errors
);

    // effects of one instruction in the reference model
    typedef struct packed {
        logic [1:0]       ntx;
        bus_req_t         tx0;
        bus_req_t         tx1;
        logic             reg_we;
        logic [REG_W-1:0] reg_idx;
        logic [XLEN-1:0]  reg_val;
        logic             mem_we;
        logic [XLEN-1:0]  next_pc;
        logic             halt;
    } step_t;

    logic [XLEN-1:0] m_mem  [256];
    logic [XLEN-1:0] m_regs [NREG];
    logic [XLEN-1:0] m_pc;
    logic            m_halt;
    bus_req_t        exp_q [$];
    bus_req_t        exp;
    step_t           st;
    int              halt_wait;
    logic            early_seen;
    logic            late_seen;
    int              err_count = 0;

    assign errors = err_count;

    function automatic step_t ref_step();
        step_t            s;
        opcode_t          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  instr;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  diff;
        instr = m_mem[m_pc[7:0]];
        op    = opcode_t'(instr[15:12]);
        rd    = instr[11:9];
        rs1   = instr[8:6];
        rs2   = instr[5:3];
        imm   = {{(XLEN-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
        a     = m_regs[rs1];
        diff  = a - m_regs[rd];
        s            = '0;
        s.ntx        = 2'd1;
        s.tx0.kind   = bus_fetch;
        s.tx0.addr   = m_pc;
        s.next_pc    = m_pc + 16'd1;
        s.reg_idx    = rd;
        case (op)
            op_add:  s.reg_val = a + m_regs[rs2];
            op_sub:  s.reg_val = a - m_regs[rs2];
            op_and:  s.reg_val = a & m_regs[rs2];
            op_or:   s.reg_val = a | m_regs[rs2];
            op_addi: s.reg_val = a + imm;
            op_lw: begin
                s.ntx      = 2'd2;
                s.tx1.kind = bus_read;
                s.tx1.addr = a + imm;
                s.reg_val  = m_mem[s.tx1.addr[7:0]];
            end
            op_sw: begin
                s.ntx       = 2'd2;
                s.tx1.kind  = bus_write;
                s.tx1.addr  = a + imm;
                s.tx1.wdata = m_regs[rd];
                s.mem_we    = 1'b1;
            end
            // branch offsets count from the word after the branch
            op_beq:  if (diff == '0) s.next_pc = m_pc + 16'd1 + imm;
            op_bgt:  if (!diff[XLEN-1] && (diff != '0)) s.next_pc = m_pc + 16'd1 + imm;
            op_halt: s.halt = 1'b1;
            default: ;
        endcase
        // r0 stays zero
        s.reg_we = (rd != '0) && (op inside {op_add, op_sub, op_and, op_or, op_addi, op_lw});
        return s;
    endfunction

    task automatic report_value(input string name, input logic [XLEN-1:0] expv,
                                input logic [XLEN-1:0] actv);
        $display("Fail at %0d ns: %s expected 0x%04h, got 0x%04h", $time, name, expv, actv);
        err_count++;
    endtask

    task automatic report_error(input string what);
        $display("Error at %0d ns: %s", $time, what);
        err_count++;
    endtask

    task automatic compare_req(input bus_req_t expv);
        if (bus_req.kind != expv.kind) begin
            report_value("bus_req.kind", XLEN'(expv.kind), XLEN'(bus_req.kind));
        end
        if (bus_req.addr != expv.addr) begin
            report_value("bus_req.addr", expv.addr, bus_req.addr);
        end
        // wdata only carries meaning on a write
        if ((expv.kind == bus_write) && (bus_req.wdata != expv.wdata)) begin
            report_value("bus_req.wdata", expv.wdata, bus_req.wdata);
        end
    endtask

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                m_mem[i[7:0]] <= init_image[i[7:0]];
            end
            for (int i = 0; i < NREG; i++) begin
                m_regs[i[REG_W-1:0]] <= '0;
            end
            m_pc       <= '0;
            m_halt     <= 1'b0;
            halt_wait  <= 0;
            early_seen <= 1'b0;
            late_seen  <= 1'b0;
            exp_q.delete();
        end else begin
            if (bus_valid && bus_ready) begin
                // next instruction starts with its fetch
                if ((exp_q.size() == 0) && !m_halt) begin
                    st = ref_step();
                    exp_q.push_back(st.tx0);
                    if (st.ntx == 2'd2) begin
                        exp_q.push_back(st.tx1);
                    end
                    if (st.reg_we) begin
                        m_regs[st.reg_idx] <= st.reg_val;
                    end
                    if (st.mem_we) begin
                        m_mem[st.tx1.addr[7:0]] <= st.tx1.wdata;
                    end
                    m_pc   <= st.next_pc;
                    m_halt <= st.halt;
                end
                if (exp_q.size() == 0) begin
                    report_error("bus transfer after the program reached halt");
                end else begin
                    exp = exp_q.pop_front();
                    compare_req(exp);
                end
            end
            if (halted && !m_halt && !early_seen) begin
                early_seen <= 1'b1;
                report_error("halted rose before the reference model reached halt");
            end
            if (halted && bus_valid && !late_seen) begin
                late_seen <= 1'b1;
                report_error("bus request raised while halted");
            end
            if (m_halt && !halted) begin
                halt_wait <= halt_wait + 1;
            end
            if (halt_wait == 8) begin
                report_error("reference model halted but halted did not rise within 8 cycles");
            end
        end
    end

endmodule

//--- sim/ls_cpu_asserts.sv
// bus protocol and register file assertions, bound into the CPU top level
`timescale 1ns/100ps

module ls_cpu_asserts import ls_pkg::*; (
    input logic             clock,
    input logic             rst_n,
    input logic             bus_valid,
    input logic             bus_ready,
    input bus_req_t         bus_req,
    input logic             halted,
    input logic             wb_en,
    input logic [REG_W-1:0] wb_rd,
    input logic [XLEN-1:0]  r0_val
);

    // request frozen until ready
    a_req_held: assert property (@(posedge clock) disable iff (!rst_n)
        bus_valid && !bus_ready |=> bus_valid && $stable(bus_req))
        else $error("bus request changed while waiting for ready");

    a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted fell without a reset");

    // a writeback aimed at r0 leaves its storage untouched
    a_r0_kept: assert property (@(posedge clock) disable iff (!rst_n)
        wb_en && (wb_rd == '0) |=> (r0_val === $past(r0_val)))
        else $error("a write to r0 changed its contents");

endmodule

bind ls_cpu ls_cpu_asserts u_asserts (
    .clock     (clock),
    .rst_n     (rst_n),
    .bus_valid (bus_valid),
    .bus_ready (bus_ready),
    .bus_req   (bus_req),
    .halted    (halted),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .r0_val    (u_decode.regs[0])
);

//--- sim/tb_ls_cpu.sv
// testbench top for the load-store CPU; runs one program without and then with bus stalls
`timescale 1ns/100ps

module tb_ls_cpu import ls_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 400 * 5 * 3;

    logic            clock;
    logic            rst_n      = 1'b0;
    logic            bus_valid;
    bus_req_t        bus_req;
    logic            bus_ready  = 1'b0;
    logic [XLEN-1:0] bus_rdata  = '0;
    logic            halted;
    logic [XLEN-1:0] mem   [256];
    logic [XLEN-1:0] image [256];
    logic            stall_mode = 1'b0;
    logic [7:0]      load_ptr;
    int              chk_errors;
    int              tb_errors   = 0;
    int              cycle_count = 0;

    ls_cpu uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .bus_valid (bus_valid),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .halted    (halted)
    );

    ls_checker u_checker (
        .clock      (clock),
        .rst_n      (rst_n),
        .bus_valid  (bus_valid),
        .bus_req    (bus_req),
        .bus_ready  (bus_ready),
        .halted     (halted),
        .init_image (image),
        .errors     (chk_errors)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // memory model, reloaded from the image while reset is low
    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i[7:0]] <= image[i[7:0]];
            end
        end else if (bus_valid && bus_ready && (bus_req.kind == bus_write)) begin
            mem[bus_req.addr[7:0]] <= bus_req.wdata;
        end
    end

    // about 60 % ready when stalls are on
    always @(negedge clock) begin
        bus_ready <= stall_mode ? (($urandom % 100) < 60) : 1'b1;
        bus_rdata <= mem[bus_req.addr[7:0]];
    end

    function automatic logic [XLEN-1:0] enc_r(opcode_t op, int rd, int rs1, int rs2);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
    endfunction

    // sw, beq and bgt put their second register in the rd slot
    function automatic logic [XLEN-1:0] enc_i(opcode_t op, int rd, int rs1, int imm);
        return {op, rd[2:0], rs1[2:0], imm[5:0]};
    endfunction

    task automatic emit(input logic [XLEN-1:0] word);
        image[load_ptr] = word;
        load_ptr = load_ptr + 8'd1;
    endtask

    task automatic build_image();
        for (int i = 0; i < 256; i++) begin
            // program half holds halt words tagged with the address
            image[i[7:0]] = (i < 128) ? (16'h9000 | 16'(i)) : 16'($urandom);
        end
        load_ptr = 8'd0;
        // r1 = 0x80, the data base
        emit(enc_i(op_addi, 1, 0, 16));
        emit(enc_r(op_add, 1, 1, 1));
        emit(enc_r(op_add, 1, 1, 1));
        emit(enc_r(op_add, 1, 1, 1));
        emit(enc_i(op_lw, 2, 1, 0));
        emit(enc_i(op_lw, 3, 1, 1));
        emit(enc_r(op_add, 4, 2, 3));
        emit(enc_i(op_sw, 4, 1, 16));
        emit(enc_r(op_sub, 4, 2, 3));
        emit(enc_i(op_sw, 4, 1, 17));
        emit(enc_r(op_and, 4, 2, 3));
        emit(enc_i(op_sw, 4, 1, 18));
        emit(enc_r(op_or, 4, 2, 3));
        emit(enc_i(op_sw, 4, 1, 19));
        emit(enc_i(op_addi, 4, 2, -7));
        emit(enc_i(op_sw, 4, 1, 20));
        emit(enc_i(op_addi, 4, 2, -32));
        emit(enc_i(op_sw, 4, 1, 21));
        // copy two data words
        emit(enc_i(op_lw, 5, 1, 2));
        emit(enc_i(op_sw, 5, 1, 22));
        emit(enc_i(op_lw, 5, 1, 31));
        emit(enc_i(op_sw, 5, 1, 23));
        // writes to r0 go nowhere
        emit(enc_i(op_addi, 0, 0, 5));
        emit(enc_r(op_add, 0, 2, 3));
        emit(enc_i(op_sw, 0, 1, 24));
        // counted loop, five passes adding 3
        emit(enc_i(op_addi, 6, 0, 5));
        emit(enc_i(op_addi, 7, 0, 0));
        emit(enc_i(op_addi, 7, 7, 3));
        emit(enc_i(op_addi, 6, 6, -1));
        emit(enc_i(op_bgt, 0, 6, -3));
        emit(enc_i(op_sw, 7, 1, 25));
        emit(enc_i(op_beq, 0, 6, 2));
        emit(enc_i(op_addi, 7, 0, 1));
        emit(enc_i(op_sw, 7, 1, 26));
        emit(enc_i(op_beq, 0, 7, 5));
        emit(enc_i(op_bgt, 6, 0, 4));
        emit(enc_i(op_sw, 7, 1, 27));
        emit(16'hF000);
        emit(enc_r(op_halt, 0, 0, 0));
    endtask

    task automatic check_word(input logic [7:0] addr, input logic [XLEN-1:0] expv);
        if (mem[addr] !== expv) begin
            $display("Fail at %0d ns: mem[0x%02h] expected 0x%04h, got 0x%04h",
                     $time, addr, expv, mem[addr]);
            tb_errors++;
        end
    endtask

    task automatic run_program(input logic stalls);
        @(negedge clock);
        stall_mode = stalls;
        rst_n      = 1'b0;
        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        while (!halted) @(posedge clock);
        // give a stray request after halt time to show up
        repeat (10) @(posedge clock);
        check_word(8'h98, 16'h0000);
        check_word(8'h99, 16'd15);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the CPU did not halt within %0d cycles", TIMEOUT_CYCLES);
            $display("tests done: %0d errors including the timeout",
                     chk_errors + tb_errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h57b7));
        build_image();
        run_program(1'b0);
        run_program(1'b1);
        $display("tests done: %0d errors (checker %0d, testbench %0d)",
                 chk_errors + tb_errors, chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb.f
design/ls_pkg.sv
design/control_unit.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/ls_cpu.sv
sim/ls_cpu_asserts.sv
sim/ls_checker.sv
sim/tb_ls_cpu.sv
